//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk50m_bufg,
	output logic RSTBTN
);

	localparam int reset_cycles = 16;

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg; // 20 ns period
	end

	// Release on a falling edge, clear of the sampling edge
	initial begin
		RSTBTN = 1'b1;
		repeat (reset_cycles) @(posedge clk50m_bufg);
		@(negedge clk50m_bufg);
		RSTBTN = 1'b0;
	end

endmodule

//--- bench/tb_video_timing.sv
`timescale 1ns/1ps

module tb_video_timing;
	import video_pkg::*;

	// About 1.18M cycles of frames and line groups plus margin
	localparam int timeout_cycles = 3_000_000;
	localparam int restart_window = 5; // Switch change to 0,0

	logic        clk50m_bufg;
	logic        RSTBTN;
	sw_code_t    sw;
	coord_t      hcount;
	coord_t      vcount;
	logic        hsync;
	logic        vsync;
	logic        de;

	logic        arm;          // New format requested
	logic        check_en;     // Checker tracking the raster
	int          wait_cnt;     // Cycles since the request was seen
	int          hist_cnt;     // Valid history entries
	int          lines_done;   // Lines fully checked
	int          target_lines;
	int          cycle_count;
	int unsigned seed_init;
	coord_t      exp_h;        // Counter model
	coord_t      exp_v;
	coord_t      hist_h [2];   // [1] is two cycles back
	coord_t      hist_v [2];
	timing_set_t cur_set;
	timing_set_t next_set;
	sw_code_t    odd_code;

	tb_clock u_tb_clock (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN)
	);

	video_timing_top u_video_timing_top (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.hcount      (hcount),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

	////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////
	// Returns {de, hsync, vsync} for one raster position
	function automatic logic [2:0] expected_outputs(input timing_set_t ts, input coord_t h,
		input coord_t v);
		logic de_exp;
		logic hs_exp;
		logic vs_exp;
		de_exp = (h <= ts.hsblnk) && (v <= ts.vsblnk);
		hs_exp = ((h > ts.hssync) && (h <= ts.hesync)) ^ ts.sync_negative; // Polarity flip
		vs_exp = ((v > ts.vssync) && (v <= ts.vesync)) ^ ts.sync_negative;
		return {de_exp, hs_exp, vs_exp};
	endfunction

	function automatic bit is_listed(input sw_code_t code);
		case (code)
			4'b0000, 4'b0001, 4'b0010, 4'b0011, 4'b1000, 4'b1001: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic sw_code_t pick_unlisted_code();
		sw_code_t code;
		code = sw_code_t'($urandom);
		while (is_listed(code)) begin
			code = sw_code_t'($urandom); // Redraw until unlisted
		end
		return code;
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			abort_run();
		end
	endtask

	// Counts now and outputs for the counts 2 cycles back
	task automatic check_cycle();
		logic [2:0] exp_out;
		check_equal("hcount", hcount, exp_h);
		check_equal("vcount", vcount, exp_v);
		if (hist_cnt == 2) begin
			exp_out = expected_outputs(cur_set, hist_h[1], hist_v[1]);
			check_equal("de", de, exp_out[2]);
			check_equal("hsync", hsync, exp_out[1]);
			check_equal("vsync", vsync, exp_out[0]);
		end
		hist_h[1] = hist_h[0];
		hist_v[1] = hist_v[0];
		hist_h[0] = hcount;
		hist_v[0] = vcount;
		if (hist_cnt < 2) hist_cnt++;
		if (exp_h == cur_set.heblnk) begin // End of line
			exp_h = '0;
			lines_done++;
			if (exp_v == cur_set.veblnk) exp_v = '0; // End of frame
			else exp_v = exp_v + coord_t'(1);
		end else begin
			exp_h = exp_h + coord_t'(1);
		end
	endtask

	// Sampled on the falling edge between DUT updates
	always @(negedge clk50m_bufg) begin
		if (arm) begin
			check_en = 1'b0; // Old set no longer trusted
			if (hcount == '0 && vcount == '0) begin
				cur_set    = next_set;
				exp_h      = '0;
				exp_v      = '0;
				hist_cnt   = 0;
				lines_done = 0;
				wait_cnt   = 0;
				check_en   = 1'b1;
				arm        = 1'b0;
			end else if (wait_cnt == restart_window - 1) begin
				$display("Counters did not return to 0,0 within %0d cycles", restart_window);
				abort_run();
			end else begin
				wait_cnt++;
			end
		end
		if (check_en) check_cycle();
	end

	always @(posedge clk50m_bufg) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			abort_run();
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	// Drive a code and wait for the lock at 0,0 and the checked lines
	task automatic run_format(input sw_code_t code, input video_format_e fmt, input int lines);
		@(negedge clk50m_bufg);
		target_lines = lines;
		sw       <= code;
		next_set <= format_timing(fmt);
		arm      <= 1'b1;
		@(negedge clk50m_bufg);
		wait (!arm);
		wait (lines_done >= target_lines);
	endtask

	initial begin
		seed_init    = $urandom(2);
		sw           = 4'b0000; // VGA from the start
		arm          = 1'b0;
		check_en     = 1'b0;
		wait_cnt     = 0;
		hist_cnt     = 0;
		lines_done   = 0;
		target_lines = 0;
		cycle_count  = 0;
		cur_set      = format_timing(fmt_vga);
		next_set     = format_timing(fmt_vga);

		repeat (4) @(negedge clk50m_bufg); // Still in reset
		check_equal("de", de, 1'b0);
		check_equal("hsync", hsync, 1'b1); // VGA idles high
		check_equal("vsync", vsync, 1'b1);
		check_equal("hcount", hcount, '0);
		check_equal("vcount", vcount, '0);
		wait (!RSTBTN);

		run_format(4'b0000, fmt_vga, 525);  // One full VGA frame
		check_equal("hcount", hcount, 11'd799); // Last pixel of the VGA frame
		check_equal("vcount", vcount, 11'd524);
		run_format(4'b0001, fmt_svga, 628); // One full SVGA frame
		odd_code = pick_unlisted_code();
		run_format(odd_code, fmt_hdtv720p, 20);
		run_format(4'b0011, fmt_xga, 20);
		run_format(4'b1000, fmt_sxga, 20);

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- filelist.f
source/video_pkg.sv
source/timing_if.sv
source/format_select.sv
source/raster_counter.sv
source/sync_gen.sv
source/video_timing_top.sv
bench/tb_clock.sv
bench/tb_video_timing.sv

//--- source/format_select.sv
`timescale 1ns/1ps

module format_select (
	input  logic                clk50m_bufg,
	input  logic                RSTBTN,
	input  video_pkg::sw_code_t sw,
	timing_if.source            tif
);
	import video_pkg::*;

	sw_code_t [sync_stages-1:0] sw_meta; // Synchronizer chain, [0] first
	sw_code_t      sw_sync;              // Stable copy of the switches
	video_format_e fmt_dec;              // Format the switches ask for
	video_format_e fmt_q;                // Format currently running
	logic          fmt_change;

	////////////////////////////////////////
	// Switch synchronizer
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= {sw_meta[sync_stages-2:0], sw};
	end

	assign sw_sync = sw_meta[sync_stages-1];

	////////////////////////////////////////
	// Code decode
	////////////////////////////////////////
	always_comb begin
		case (sw_sync)
			fmt_vga:    fmt_dec = fmt_vga;
			fmt_svga:   fmt_dec = fmt_svga;
			fmt_xga:    fmt_dec = fmt_xga;
			fmt_sxga:   fmt_dec = fmt_sxga;
			fmt_camera: fmt_dec = fmt_camera;
			default:    fmt_dec = fmt_hdtv720p; // 0010 and every unlisted code
		endcase
	end

	assign fmt_change = (fmt_dec != fmt_q); // fmt_none never matches

	// Load new timing and kick the raster
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			fmt_q       <= fmt_none;                // Forces a load after reset
			tif.tset    <= format_timing(fmt_vga);  // Defined set until first load
			tif.restart <= 1'b0;
		end else begin
			tif.restart <= fmt_change;
			if (fmt_change) begin
				fmt_q    <= fmt_dec;
				tif.tset <= format_timing(fmt_dec);
			end
		end
	end

	// A load settles fmt_q, so restart cannot repeat back to back
	a_restart_pulse: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		tif.restart |=> !tif.restart);

endmodule

//--- source/raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
	input  logic              clk50m_bufg,
	input  logic              RSTBTN,
	timing_if.sink            tif,
	output video_pkg::coord_t hcount,
	output video_pkg::coord_t vcount
);
	import video_pkg::*;

	logic h_wrap; // Last pixel of the line
	logic v_wrap; // Last line of the frame

	// Compare with >= so a shorter new format can never run away
	assign h_wrap = (hcount >= tif.tset.heblnk);
	assign v_wrap = (vcount >= tif.tset.veblnk);

	////////////////////////////////////////
	// Position counters
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || tif.restart) begin
			hcount <= '0; // Restart from top left
			vcount <= '0;
		end else if (h_wrap) begin
			hcount <= '0;
			if (v_wrap) begin
				vcount <= '0; // New frame
			end else begin
				vcount <= vcount + coord_t'(1);
			end
		end else begin
			hcount <= hcount + coord_t'(1);
		end
	end

	// Holds except in the cycle a new, shorter set arrives
	a_hcount_range: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!tif.restart |-> (hcount <= tif.tset.heblnk));

endmodule

//--- source/sync_gen.sv
`timescale 1ns/1ps

module sync_gen (
	input  logic              clk50m_bufg,
	input  logic              RSTBTN,
	timing_if.sink            tif,
	input  video_pkg::coord_t hcount,
	input  video_pkg::coord_t vcount,
	output logic              hsync,
	output logic              vsync,
	output logic              de
);

	logic hblnk;     // Past the last live pixel
	logic vblnk;     // Past the last live line
	logic active;
	logic hsync_raw; // Positive-polarity pulses
	logic vsync_raw;
	logic hsync_q1;  // First output stage
	logic vsync_q1;
	logic de_q1;

	////////////////////////////////////////
	// Threshold compares
	////////////////////////////////////////
	assign hblnk     = (hcount > tif.tset.hsblnk);
	assign vblnk     = (vcount > tif.tset.vsblnk);
	assign active    = !hblnk && !vblnk;
	assign hsync_raw = (hcount > tif.tset.hssync) && (hcount <= tif.tset.hesync);
	assign vsync_raw = (vcount > tif.tset.vssync) && (vcount <= tif.tset.vesync);

	////////////////////////////////////////
	// Polarity and two-stage pipeline
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q1 <= tif.tset.sync_negative; // Inactive level
			vsync_q1 <= tif.tset.sync_negative;
			de_q1    <= 1'b0;
			hsync    <= tif.tset.sync_negative;
			vsync    <= tif.tset.sync_negative;
			de       <= 1'b0;
		end else begin
			hsync_q1 <= hsync_raw ^ tif.tset.sync_negative;
			vsync_q1 <= vsync_raw ^ tif.tset.sync_negative;
			de_q1    <= active;
			hsync    <= hsync_q1; // Outputs lag the counts by 2
			vsync    <= vsync_q1;
			de       <= de_q1;
		end
	end

	// Polarity in use two cycles back defines the idle level
	a_de_hsync_idle: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		de |-> (hsync == $past(tif.tset.sync_negative, 2)));

endmodule

//--- source/timing_if.sv
`timescale 1ns/1ps

// Active timing set plus restart strobe, no handshake
interface timing_if;
	import video_pkg::*;

	timing_set_t tset;    // Changes only alongside restart
	logic        restart; // One-cycle pulse

	// Format selector side
	modport source (
		output tset,
		output restart
	);

	// Raster counter and sync generator side
	modport sink (
		input tset,
		input restart
	);

endinterface

//--- source/video_pkg.sv
package video_pkg;

	////////////////////////////////////////
	// Widths and basic types
	////////////////////////////////////////
	localparam int coord_w     = 11; // Pixel and line counts
	localparam int sync_stages = 2;  // Switch synchronizer depth

	typedef logic [coord_w-1:0] coord_t;
	typedef logic [3:0]         sw_code_t; // Raw switch code

	// Encoding equals the switch code
	typedef enum logic [3:0] {
		fmt_vga      = 4'b0000,
		fmt_svga     = 4'b0001,
		fmt_hdtv720p = 4'b0010, // Also any unlisted code
		fmt_xga      = 4'b0011,
		fmt_sxga     = 4'b1000,
		fmt_camera   = 4'b1001,
		fmt_none     = 4'b1111  // Held after reset only
	} video_format_e;

	// Thresholds are inclusive end positions
	typedef struct packed {
		coord_t hsblnk;        // Last live pixel
		coord_t hssync;        // Sync starts after this one
		coord_t hesync;        // Last sync pixel
		coord_t heblnk;        // Last pixel of the line
		coord_t vsblnk;        // Last live line
		coord_t vssync;
		coord_t vesync;
		coord_t veblnk;        // Last line of the frame
		logic   sync_negative; // Active low syncs
	} timing_set_t;

	////////////////////////////////////////
	// Per-format raster constants
	////////////////////////////////////////
	// 640x480@60, active low syncs
	localparam coord_t vga_hpixels = 11'd640;
	localparam coord_t vga_hfp     = 11'd16;
	localparam coord_t vga_hsw     = 11'd96;
	localparam coord_t vga_hbp     = 11'd48;
	localparam coord_t vga_vlines  = 11'd480;
	localparam coord_t vga_vfp     = 11'd10;
	localparam coord_t vga_vsw     = 11'd2;
	localparam coord_t vga_vbp     = 11'd33; // 525 lines total

	// 800x600@60
	localparam coord_t svga_hpixels = 11'd800;
	localparam coord_t svga_hfp     = 11'd40;
	localparam coord_t svga_hsw     = 11'd128;
	localparam coord_t svga_hbp     = 11'd88;
	localparam coord_t svga_vlines  = 11'd600;
	localparam coord_t svga_vfp     = 11'd1;
	localparam coord_t svga_vsw     = 11'd4;
	localparam coord_t svga_vbp     = 11'd23;

	// 1024x768@60, active low syncs
	localparam coord_t xga_hpixels = 11'd1024;
	localparam coord_t xga_hfp     = 11'd24;
	localparam coord_t xga_hsw     = 11'd136;
	localparam coord_t xga_hbp     = 11'd160;
	localparam coord_t xga_vlines  = 11'd768;
	localparam coord_t xga_vfp     = 11'd3;
	localparam coord_t xga_vsw     = 11'd6;
	localparam coord_t xga_vbp     = 11'd29;

	// 1280x1024@60, widest line of the set
	localparam coord_t sxga_hpixels = 11'd1280;
	localparam coord_t sxga_hfp     = 11'd48;
	localparam coord_t sxga_hsw     = 11'd112;
	localparam coord_t sxga_hbp     = 11'd248;
	localparam coord_t sxga_vlines  = 11'd1024;
	localparam coord_t sxga_vfp     = 11'd1;
	localparam coord_t sxga_vsw     = 11'd3;
	localparam coord_t sxga_vbp     = 11'd38;

	// 1280x720@60
	localparam coord_t hd_hpixels = 11'd1280;
	localparam coord_t hd_hfp     = 11'd110;
	localparam coord_t hd_hsw     = 11'd40;
	localparam coord_t hd_hbp     = 11'd220;
	localparam coord_t hd_vlines  = 11'd720;
	localparam coord_t hd_vfp     = 11'd5;
	localparam coord_t hd_vsw     = 11'd5;
	localparam coord_t hd_vbp     = 11'd20;

	// Camera variant of 720p, slightly shorter sync
	localparam coord_t cam_hpixels = 11'd1280;
	localparam coord_t cam_hfp     = 11'd110;
	localparam coord_t cam_hsw     = 11'd39;
	localparam coord_t cam_hbp     = 11'd220;
	localparam coord_t cam_vlines  = 11'd720;
	localparam coord_t cam_vfp     = 11'd4;
	localparam coord_t cam_vsw     = 11'd4;
	localparam coord_t cam_vbp     = 11'd22;

	// Live, front porch, sync, back porch accumulate in that order
	function automatic timing_set_t make_set(
		input coord_t hpix,
		input coord_t hfp,
		input coord_t hsw,
		input coord_t hbp,
		input coord_t vlin,
		input coord_t vfp,
		input coord_t vsw,
		input coord_t vbp,
		input logic   neg
	);
		timing_set_t ts;
		ts.hsblnk        = hpix - coord_t'(1);
		ts.hssync        = ts.hsblnk + hfp;
		ts.hesync        = ts.hssync + hsw;
		ts.heblnk        = ts.hesync + hbp;
		ts.vsblnk        = vlin - coord_t'(1);
		ts.vssync        = ts.vsblnk + vfp;
		ts.vesync        = ts.vssync + vsw;
		ts.veblnk        = ts.vesync + vbp;
		ts.sync_negative = neg;
		return ts;
	endfunction

	function automatic timing_set_t format_timing(input video_format_e fmt);
		case (fmt)
			fmt_vga:    return make_set(vga_hpixels, vga_hfp, vga_hsw, vga_hbp,
				vga_vlines, vga_vfp, vga_vsw, vga_vbp, 1'b1);
			fmt_svga:   return make_set(svga_hpixels, svga_hfp, svga_hsw, svga_hbp,
				svga_vlines, svga_vfp, svga_vsw, svga_vbp, 1'b0);
			fmt_xga:    return make_set(xga_hpixels, xga_hfp, xga_hsw, xga_hbp,
				xga_vlines, xga_vfp, xga_vsw, xga_vbp, 1'b1);
			fmt_sxga:   return make_set(sxga_hpixels, sxga_hfp, sxga_hsw, sxga_hbp,
				sxga_vlines, sxga_vfp, sxga_vsw, sxga_vbp, 1'b0);
			fmt_camera: return make_set(cam_hpixels, cam_hfp, cam_hsw, cam_hbp,
				cam_vlines, cam_vfp, cam_vsw, cam_vbp, 1'b0);
			default:    return make_set(hd_hpixels, hd_hfp, hd_hsw, hd_hbp,
				hd_vlines, hd_vfp, hd_vsw, hd_vbp, 1'b0); // 720p fallback
		endcase
	endfunction

endpackage

//--- source/video_timing_top.sv
`timescale 1ns/1ps

module video_timing_top (
	input  logic                clk50m_bufg,
	input  logic                RSTBTN,
	input  video_pkg::sw_code_t sw,     // Format switches
	output video_pkg::coord_t   hcount,
	output video_pkg::coord_t   vcount,
	output logic                hsync,
	output logic                vsync,
	output logic                de
);

	timing_if tif (); // Selector to counter and sync generator

	////////////////////////////////////////
	// Format selection
	////////////////////////////////////////
	format_select u_format_select (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.tif         (tif.source)
	);

	////////////////////////////////////////
	// Raster position
	////////////////////////////////////////
	raster_counter u_raster_counter (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.tif         (tif.sink),
		.hcount      (hcount),
		.vcount      (vcount)
	);

	// Sync and enable, 2 cycles behind the counts
	sync_gen u_sync_gen (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.tif         (tif.sink),
		.hcount      (hcount),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

endmodule
